// File: bench/apb_ram_vectors.svh
`ifndef APB_RAM_VECTORS_SVH
`define APB_RAM_VECTORS_SVH

// columns: name, write, byte address, write data, strobe, expected pslverr.
// read rows leave data and strobe at zero, their data comes from the model.
function automatic void load_vectors();
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reset clear
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	add_vector("clear_first", 1'b0, 32'h0000_0000, 32'h0000_0000, 4'h0, 1'b0);
	add_vector("clear_last", 1'b0, 32'h0000_03fc, 32'h0000_0000, 4'h0, 1'b0);
	add_vector("clear_middle", 1'b0, 32'h0000_0200, 32'h0000_0000, 4'h0, 1'b0);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// whole words and byte lanes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	add_vector("full_write", 1'b1, 32'h0000_0010, 32'hdead_beef, 4'hf, 1'b0);
	add_vector("full_read", 1'b0, 32'h0000_0010, 32'h0000_0000, 4'h0, 1'b0);
	add_vector("lane_base_write", 1'b1, 32'h0000_0020, 32'h1122_3344, 4'hf, 1'b0);
	add_vector("lane0_write", 1'b1, 32'h0000_0020, 32'haaaa_aaaa, 4'h1, 1'b0);
	add_vector("lane0_read", 1'b0, 32'h0000_0020, 32'h0000_0000, 4'h0, 1'b0);
	add_vector("even_lanes_write", 1'b1, 32'h0000_0020, 32'h5566_7788, 4'h5, 1'b0);
	add_vector("even_lanes_read", 1'b0, 32'h0000_0020, 32'h0000_0000, 4'h0, 1'b0);
	add_vector("odd_lanes_write", 1'b1, 32'h0000_0020, 32'h99bb_ccdd, 4'ha, 1'b0);
	// the two low address bits pick a byte and must not move the word.
	add_vector("odd_lanes_read", 1'b0, 32'h0000_0022, 32'h0000_0000, 4'h0, 1'b0);
	add_vector("no_lanes_write", 1'b1, 32'h0000_0020, 32'hffff_ffff, 4'h0, 1'b0);
	add_vector("no_lanes_read", 1'b0, 32'h0000_0020, 32'h0000_0000, 4'h0, 1'b0);
	add_vector("last_word_write", 1'b1, 32'h0000_03fc, 32'h0bad_cafe, 4'hf, 1'b0);
	add_vector("last_word_read", 1'b0, 32'h0000_03fc, 32'h0000_0000, 4'h0, 1'b0);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// out of range
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	add_vector("oor_write", 1'b1, 32'h0000_0400, 32'hcafe_f00d, 4'hf, 1'b1);
	add_vector("oor_read", 1'b0, 32'h0000_0400, 32'h0000_0000, 4'h0, 1'b1);
	add_vector("alias_read", 1'b0, 32'h0000_0000, 32'h0000_0000, 4'h0, 1'b0);
	add_vector("oor_high_write", 1'b1, 32'h8000_0010, 32'h1234_5678, 4'hf, 1'b1);
	add_vector("oor_high_read", 1'b0, 32'h8000_0010, 32'h0000_0000, 4'h0, 1'b1);
	add_vector("alias_full_read", 1'b0, 32'h0000_0010, 32'h0000_0000, 4'h0, 1'b0);
endfunction

`endif

// File: bench/apb_ram_tb.sv
`timescale 1ns/1ps
`include "ram_macros.svh"

module apb_ram_tb;

	localparam int ready_timeout = 16;
	localparam int num_words = 1 << `RAM_ADDR_WIDTH;
	localparam int random_ops = 48;

	logic clk;
	logic resetn;
	logic psel;
	logic penable;
	logic pwrite;
	logic [31:0] paddr;
	logic [31:0] pwdata;
	logic [3:0] pstrb;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;

	// reference copy of the scratchpad contents.
	logic [31:0] model [num_words];

	string vec_name [$];
	bit vec_write [$];
	logic [31:0] vec_addr [$];
	logic [31:0] vec_data [$];
	logic [3:0] vec_strb [$];
	bit vec_err [$];

	apb_ram_top dut (
		.clk(clk),
		.resetn(resetn),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.pstrb(pstrb),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic void add_vector(input string name, input bit is_write,
			input logic [31:0] addr, input logic [31:0] data, input logic [3:0] strb,
			input bit exp_err);
		vec_name.push_back(name);
		vec_write.push_back(is_write);
		vec_addr.push_back(addr);
		vec_data.push_back(data);
		vec_strb.push_back(strb);
		vec_err.push_back(exp_err);
	endfunction

	`include "apb_ram_vectors.svh"

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reporting
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1, "simulation stopped at the first error.");
	endtask

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			stop_run($sformatf("MISMATCH %s: expected %h, actual %h", name, expected, actual));
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// only byte addresses below 1024 reach the array, lanes follow the strobe.
	function automatic void model_write(input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] strb);
		if (addr < 32'd1024) begin
			for (int i = 0; i < 4; i++) begin
				if (strb[i]) begin
					model[addr[9:2]][8*i +: 8] = data[8*i +: 8];
				end
			end
		end
	endfunction

	function automatic logic [31:0] model_read(input logic [31:0] addr);
		return model[addr[9:2]];
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// APB driver
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// counts the edges from the first access cycle until pready is seen.
	task automatic wait_ready(input string name, output int waits);
		waits = 0;
		@(posedge clk);
		while (pready !== 1'b1) begin
			check({name, " prdata while waiting"}, 32'h0, prdata);
			check({name, " pslverr while waiting"}, 32'h0, {31'b0, pslverr});
			waits++;
			if (waits > ready_timeout) begin
				stop_run($sformatf("timeout: %s never saw pready.", name));
			end
			@(posedge clk);
		end
	endtask

	task automatic release_bus();
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pstrb = 4'h0;
	endtask

	task automatic apb_write(input string name, input logic [31:0] addr,
			input logic [31:0] data, input logic [3:0] strb, output logic err,
			output int waits);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		pstrb = strb;
		@(negedge clk);
		penable = 1'b1;
		wait_ready(name, waits);
		err = pslverr;
		@(negedge clk);
		release_bus();
	endtask

	task automatic apb_read(input string name, input logic [31:0] addr,
			output logic [31:0] data, output logic err, output int waits);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		pstrb = 4'h0;
		@(negedge clk);
		penable = 1'b1;
		wait_ready(name, waits);
		data = prdata;
		err = pslverr;
		@(negedge clk);
		release_bus();
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// sequences
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic run_op(input string name, input bit is_write, input logic [31:0] addr,
			input logic [31:0] data, input logic [3:0] strb, input bit exp_err);
		logic [31:0] rdata;
		logic err;
		int waits;
		if (is_write) begin
			apb_write(name, addr, data, strb, err, waits);
			check({name, " wait states"}, 32'd0, waits);
			model_write(addr, data, strb);
		end else begin
			apb_read(name, addr, rdata, err, waits);
			if (exp_err) begin
				check({name, " wait states"}, 32'd0, waits);
				check({name, " data"}, 32'h0, rdata);
			end else begin
				check({name, " wait states"}, `RAM_READ_LATENCY, waits);
				check({name, " data"}, model_read(addr), rdata);
			end
		end
		check({name, " pslverr"}, {31'b0, exp_err}, {31'b0, err});
	endtask

	// reads mostly revisit written words so that the data is not just zero.
	task automatic run_random();
		logic [31:0] addr;
		int written [$];
		for (int n = 0; n < random_ops; n++) begin
			if (written.size() == 0 || $urandom_range(1, 0) == 1) begin
				addr = {22'b0, 8'($urandom_range(num_words - 1, 0)), 2'b00};
				written.push_back(addr);
				run_op($sformatf("random_write_%0d", n), 1'b1, addr, $urandom(),
					4'($urandom_range(15, 0)), 1'b0);
			end else begin
				addr = written[$urandom_range(written.size() - 1, 0)];
				run_op($sformatf("random_read_%0d", n), 1'b0, addr, 32'h0, 4'h0, 1'b0);
			end
		end
	endtask

	initial begin
		void'($urandom(32'hb792_67e7));
		resetn = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 32'h0;
		pwdata = 32'h0;
		pstrb = 4'h0;
		for (int w = 0; w < num_words; w++) begin
			model[w] = 32'h0;
		end
		load_vectors();

		repeat (5) @(posedge clk);
		@(negedge clk);
		resetn = 1'b0;

		for (int i = 0; i < vec_name.size(); i++) begin
			run_op(vec_name[i], vec_write[i], vec_addr[i], vec_data[i], vec_strb[i],
				vec_err[i]);
		end
		run_random();

		$display("All checks passed");
		$finish;
	end

endmodule

// File: compile.f
+incdir+src
+incdir+bench
src/apb_pkg.sv
src/ram_pkg.sv
src/ram_port_if.sv
src/ram_single_port.sv
src/apb_ram_bridge.sv
src/apb_ram_top.sv
bench/apb_ram_tb.sv

// File: src/apb_pkg.sv
package apb_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// APB completer signal types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// byte address as seen on the bus.
	// the two low bits select a byte inside the word and are ignored here.
	typedef logic [31:0] apb_addr_t;

	// read and write data share one width.
	typedef logic [31:0] apb_data_t;

	// one strobe bit per byte of apb_data_t.
	// bit 0 covers pwdata[7:0].
	typedef logic [3:0] apb_strb_t;

endpackage

// File: src/apb_ram_bridge.sv
`timescale 1ns/1ps
`include "ram_macros.svh"

module apb_ram_bridge #(
	parameter int read_latency = `RAM_READ_LATENCY
) (
	input logic clk,
	input logic resetn,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input apb_pkg::apb_addr_t paddr,
	input apb_pkg::apb_data_t pwdata,
	input apb_pkg::apb_strb_t pstrb,
	output apb_pkg::apb_data_t prdata,
	output logic pready,
	output logic pslverr
);

	// wide enough to hold read_latency, and one bit when it is zero.
	localparam int cnt_width = $clog2(read_latency + 2);

	logic access;
	logic first;
	logic in_range;
	logic issue_read;
	logic issued;
	logic rd_ready;
	logic hold_addr;
	logic [cnt_width-1:0] rd_count;

	ram_port_if ram_port ();

	ram_single_port #(
		.read_latency(read_latency)
	) u_mem (
		.clk(clk),
		.resetn(resetn),
		.port(ram_port.memory)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// decode and request
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign access = psel & penable;

	// issued is high in every access cycle after the first one.
	assign first = access & ~issued;

	// byte addresses from 1024 upwards fall outside the array.
	assign in_range = (paddr[31:`RAM_ADDR_WIDTH+2] == '0);
	assign issue_read = first & in_range & ~pwrite;

	assign ram_port.en = first & in_range;
	assign ram_port.addr = paddr[`RAM_ADDR_WIDTH+1:2];
	assign ram_port.strobe = pwrite ? pstrb : '0;
	assign ram_port.wdata.word = pwdata;

	always_ff @(posedge clk) begin
		if (resetn) begin
			issued <= 1'b0;
		end else begin
			issued <= access;
		end
	end

	// counts down the cycles a read spends in the memory pipeline.
	always_ff @(posedge clk) begin
		if (resetn) begin
			rd_count <= '0;
		end else if (issue_read && read_latency != 0) begin
			rd_count <= cnt_width'(read_latency);
		end else if (rd_count != '0) begin
			rd_count <= rd_count - 1'b1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// response
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign rd_ready = (issue_read & (read_latency == 0)) | (rd_count == cnt_width'(1));
	assign pready = (first & (pwrite | ~in_range)) | rd_ready;
	assign pslverr = first & ~in_range;
	assign prdata = rd_ready ? ram_port.rdata : '0;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// bus protocol checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// cycles that must be followed by another cycle of the same transfer.
	assign hold_addr = (psel & ~penable) | (first & ~pready) | (rd_count > cnt_width'(1));

	a_penable_psel: assert property (
		@(posedge clk) disable iff (resetn)
		penable |-> psel
	) else $error("penable high without psel.");

	a_read_strobe: assert property (
		@(posedge clk) disable iff (resetn)
		(psel && !pwrite) |-> (pstrb == '0)
	) else $error("non-zero pstrb on a read.");

	a_addr_stable: assert property (
		@(posedge clk) disable iff (resetn)
		hold_addr |=> $stable(paddr)
	) else $error("paddr changed before the transfer completed.");

endmodule

// File: src/apb_ram_top.sv
`timescale 1ns/1ps
`include "ram_macros.svh"

module apb_ram_top (
	input logic clk,
	input logic resetn,

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// APB completer
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	input logic psel,
	input logic penable,
	input logic pwrite,
	input apb_pkg::apb_addr_t paddr,
	input apb_pkg::apb_data_t pwdata,
	input apb_pkg::apb_strb_t pstrb,
	output apb_pkg::apb_data_t prdata,
	output logic pready,
	output logic pslverr
);

	// reads complete RAM_READ_LATENCY cycles after the first access cycle.
	apb_ram_bridge #(
		.read_latency(`RAM_READ_LATENCY)
	) u_bridge (
		.clk(clk),
		.resetn(resetn),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.pstrb(pstrb),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

endmodule

// File: src/ram_macros.svh
`ifndef RAM_MACROS_SVH
`define RAM_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// scratchpad geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// word address bits, so the array holds 2 ** 8 = 256 words.
`define RAM_ADDR_WIDTH 8

`define RAM_DATA_WIDTH 32
`define RAM_BYTE_WIDTH 8

// byte lanes per word.
`define RAM_LANES (`RAM_DATA_WIDTH / `RAM_BYTE_WIDTH)

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// timing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// cycles from the sampling edge of a read to valid data.
`define RAM_READ_LATENCY 2

`endif

// File: src/ram_pkg.sv
`include "ram_macros.svh"

package ram_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// memory port types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic [`RAM_ADDR_WIDTH-1:0] ram_addr_t;

	// one enable per byte lane, a zero strobe marks a read.
	typedef logic [`RAM_LANES-1:0] ram_strobe_t;

	typedef logic [`RAM_DATA_WIDTH-1:0] ram_word_t;

	typedef logic [`RAM_LANES-1:0][`RAM_BYTE_WIDTH-1:0] ram_lanes_t;

	// the bus side sees a whole word, the write logic sees lanes.
	typedef union packed {
		ram_word_t word;
		ram_lanes_t lanes;
	} ram_view_t;

endpackage

// File: src/ram_port_if.sv
`timescale 1ns/1ps

interface ram_port_if;
	import ram_pkg::*;

	// one access per cycle while en is high.
	logic en;
	ram_addr_t addr;
	ram_strobe_t strobe;
	ram_view_t wdata;
	ram_word_t rdata;

	modport requester (
		output en,
		output addr,
		output strobe,
		output wdata,
		input rdata
	);

	modport memory (
		input en,
		input addr,
		input strobe,
		input wdata,
		output rdata
	);

endinterface

// File: src/ram_single_port.sv
`timescale 1ns/1ps
`include "ram_macros.svh"

module ram_single_port #(
	parameter int read_latency = `RAM_READ_LATENCY
) (
	input logic clk,
	input logic resetn,
	ram_port_if.memory port
);
	import ram_pkg::*;

	localparam int num_words = 1 << `RAM_ADDR_WIDTH;

	ram_view_t mem [num_words];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// write side
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// reset wipes the whole array so that the scratchpad starts at zero.
	always_ff @(posedge clk) begin
		if (resetn) begin
			for (int w = 0; w < num_words; w++) begin
				mem[w] <= '0;
			end
		end else if (port.en) begin
			for (int i = 0; i < `RAM_LANES; i++) begin
				if (port.strobe[i]) begin
					mem[port.addr].lanes[i] <= port.wdata.lanes[i];
				end
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// read side
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	if (read_latency == 0) begin : g_comb_read

		assign port.rdata = mem[port.addr].word;

	end else begin : g_pipe_read

		ram_word_t stage [read_latency];

		// the first stage samples before the write above lands, which makes
		// the port read-first. later stages only delay the word.
		always_ff @(posedge clk) begin
			if (port.en) begin
				stage[0] <= mem[port.addr].word;
			end
			for (int s = 1; s < read_latency; s++) begin
				stage[s] <= stage[s-1];
			end
		end

		assign port.rdata = stage[read_latency-1];

	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// an unknown index would silently corrupt or skip a word.
	a_addr_known: assert property (
		@(posedge clk) disable iff (resetn)
		port.en |-> !$isunknown(port.addr)
	) else $error("memory enabled with an unknown address.");

	// an unknown strobe would leave open which lanes are written.
	a_strobe_known: assert property (
		@(posedge clk) disable iff (resetn)
		port.en |-> !$isunknown(port.strobe)
	) else $error("memory enabled with an unknown strobe.");

endmodule
